//--- hw/local_mem_pkg.sv
// ====================
// Local memory subsystem definitions
// Sizes, counter types and the request and response payloads that
// travel between the ports, arbiter, burst mapper, pipes and memory
// ====================

package local_mem_pkg;

    localparam int ADDR_W                = 10;
    localparam int DATA_W                = 32;
    // Port side bursts reach 16 beats, the memory side only 4
    localparam int AFU_BURST_W           = 5;
    localparam int FIU_MAX_BURST         = 4;
    localparam int NUM_PORTS             = 2;
    localparam int PORT_W                = 1;
    localparam int PORT_REQ_CREDITS      = 4;
    localparam int MEM_REQ_CREDITS       = 4;
    localparam int NUM_TIMING_REG_STAGES = 2;
    // Input buffer depth of the burst mapper, also the arbiter's credit pool
    localparam int MAP_IN_DEPTH          = 2;

    typedef logic [ADDR_W-1:0]      addr_t;
    typedef logic [AFU_BURST_W-1:0] burst_t;
    typedef logic [PORT_W-1:0]      port_t;

    // Pointer and occupancy types for the three request queues
    typedef logic [$clog2(PORT_REQ_CREDITS)-1:0]   port_ptr_t;
    typedef logic [$clog2(PORT_REQ_CREDITS+1)-1:0] port_cnt_t;
    typedef logic [$clog2(MAP_IN_DEPTH)-1:0]       map_ptr_t;
    typedef logic [$clog2(MAP_IN_DEPTH+1)-1:0]     map_cnt_t;
    typedef logic [$clog2(MEM_REQ_CREDITS)-1:0]    mem_ptr_t;
    typedef logic [$clog2(MEM_REQ_CREDITS+1)-1:0]  mem_cnt_t;

    typedef enum logic {
        CMD_READ,
        CMD_WRITE
    } mem_cmd_e;

    // One request; port is the tag stamped by the arbiter
    typedef struct packed {
        mem_cmd_e            cmd;
        addr_t               addr;
        burst_t              burst;
        logic [DATA_W-1:0]   wdata;
        port_t               port;
    } mem_req_t;

    // One read beat
    typedef struct packed {
        logic [DATA_W-1:0]   rdata;
        port_t               port;
    } mem_rsp_t;

endpackage

//--- hw/credit_reg_pipe.sv
// ====================
// Credit register pipeline
// Delays a payload forward and its credit return backward by the
// same number of register stages
// ====================

module credit_reg_pipe
#(
    parameter type payload_t    = logic,
    parameter int  N_REG_STAGES = 1
)
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_credit,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_credit
);

    if (N_REG_STAGES == 0)
    begin : g_wire
        assign out_valid = in_valid;
        assign out_data  = in_data;
        assign in_credit = out_credit;
    end
    else
    begin : g_reg
        logic     valid_q  [N_REG_STAGES];
        logic     credit_q [N_REG_STAGES];
        payload_t data_q   [N_REG_STAGES];

        // The sender counts credits end to end, so no stage ever has to stall
        always_ff @(posedge clk or negedge rst_n)
        begin
            if (!rst_n)
            begin
                for (int i = 0; i < N_REG_STAGES; i++)
                begin
                    valid_q[i]  <= 1'b0;
                    credit_q[i] <= 1'b0;
                end
            end
            else
            begin
                valid_q[0]  <= in_valid;
                credit_q[0] <= out_credit;
                for (int i = 1; i < N_REG_STAGES; i++)
                begin
                    valid_q[i]  <= valid_q[i-1];
                    credit_q[i] <= credit_q[i-1];
                end
            end
        end

        always_ff @(posedge clk)
        begin
            data_q[0] <= in_data;
            for (int i = 1; i < N_REG_STAGES; i++)
            begin
                data_q[i] <= data_q[i-1];
            end
        end

        assign out_valid = valid_q[N_REG_STAGES-1];
        assign out_data  = data_q[N_REG_STAGES-1];
        // Credits run against the data, entering at the far end
        assign in_credit = credit_q[N_REG_STAGES-1];
    end

endmodule

//--- hw/burst_mapper.sv
// ====================
// Burst mapper
// Cuts port-side read bursts into chunks of at most FIU_MAX_BURST beats
// Writes go through untouched
// ====================

module burst_mapper
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  local_mem_pkg::mem_req_t in_req,
    output logic                    in_credit,
    output logic                    out_valid,
    output local_mem_pkg::mem_req_t out_req,
    input  logic                    out_credit
);

    local_mem_pkg::mem_req_t  buf_q [local_mem_pkg::MAP_IN_DEPTH];
    local_mem_pkg::map_ptr_t  wr_ptr_q;
    local_mem_pkg::map_ptr_t  rd_ptr_q;
    local_mem_pkg::map_cnt_t  cnt_q;
    local_mem_pkg::mem_cnt_t  credit_q;
    local_mem_pkg::burst_t    rem_q;
    local_mem_pkg::addr_t     addr_q;
    logic                     active_q;

    local_mem_pkg::mem_req_t  head;
    local_mem_pkg::addr_t     cur_addr;
    local_mem_pkg::burst_t    cur_rem;
    local_mem_pkg::burst_t    chunk;
    logic                     last_chunk;
    logic                     send;

    assign head = buf_q[rd_ptr_q];

    // Once the first chunk is out, the running address and beat count take over
    assign cur_addr = active_q ? addr_q : head.addr;
    assign cur_rem  = active_q ? rem_q : head.burst;

    always_comb
    begin
        if (head.cmd == local_mem_pkg::CMD_READ &&
            cur_rem > local_mem_pkg::burst_t'(local_mem_pkg::FIU_MAX_BURST))
        begin
            chunk      = local_mem_pkg::burst_t'(local_mem_pkg::FIU_MAX_BURST);
            last_chunk = 1'b0;
        end
        else
        begin
            chunk      = cur_rem;
            last_chunk = 1'b1;
        end
    end

    // One chunk per cycle while the memory side still has credits
    assign send      = (cnt_q != '0) && (credit_q != '0);
    assign out_valid = send;
    assign in_credit = send && last_chunk;

    always_comb
    begin
        out_req       = head;
        out_req.addr  = cur_addr;
        out_req.burst = chunk;
    end

    always_ff @(posedge clk)
    begin
        if (in_valid)
        begin
            buf_q[wr_ptr_q] <= in_req;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
            credit_q <= local_mem_pkg::mem_cnt_t'(local_mem_pkg::MEM_REQ_CREDITS);
            active_q <= 1'b0;
            rem_q    <= '0;
            addr_q   <= '0;
        end
        else
        begin
            if (in_valid)
            begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            case ({in_valid, in_credit})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;
            endcase
            case ({out_credit, send})
                2'b10:   credit_q <= credit_q + 1'b1;
                2'b01:   credit_q <= credit_q - 1'b1;
                default: credit_q <= credit_q;
            endcase
            if (send)
            begin
                // Entry leaves the buffer with its final chunk
                if (last_chunk)
                begin
                    rd_ptr_q <= rd_ptr_q + 1'b1;
                    active_q <= 1'b0;
                end
                else
                begin
                    active_q <= 1'b1;
                    rem_q    <= cur_rem - chunk;
                    addr_q   <= cur_addr + local_mem_pkg::addr_t'(chunk);
                end
            end
        end
    end

endmodule

//--- hw/mem_port_arbiter.sv
// ====================
// Port arbiter
// Buffers each port's requests, grants round-robin toward the burst
// mapper under credits and routes read beats back by port tag
// ====================

module mem_port_arbiter
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req_valid  [local_mem_pkg::NUM_PORTS],
    input  local_mem_pkg::mem_req_t req        [local_mem_pkg::NUM_PORTS],
    output logic                    req_credit [local_mem_pkg::NUM_PORTS],
    output logic                    down_valid,
    output local_mem_pkg::mem_req_t down_req,
    input  logic                    down_credit,
    input  logic                    mem_rsp_valid,
    input  local_mem_pkg::mem_rsp_t mem_rsp,
    output logic                    rsp_valid  [local_mem_pkg::NUM_PORTS],
    output local_mem_pkg::mem_rsp_t rsp        [local_mem_pkg::NUM_PORTS]
);

    local_mem_pkg::mem_req_t   fifo_q [local_mem_pkg::NUM_PORTS][local_mem_pkg::PORT_REQ_CREDITS];
    local_mem_pkg::port_ptr_t  wr_ptr_q [local_mem_pkg::NUM_PORTS];
    local_mem_pkg::port_ptr_t  rd_ptr_q [local_mem_pkg::NUM_PORTS];
    local_mem_pkg::port_cnt_t  cnt_q    [local_mem_pkg::NUM_PORTS];
    local_mem_pkg::mem_req_t   head     [local_mem_pkg::NUM_PORTS];
    local_mem_pkg::map_cnt_t   dn_cnt_q;
    local_mem_pkg::port_t      last_q;
    local_mem_pkg::port_t      grant_idx;
    logic                      grant_any;

    // ====================
    // Round-robin grant
    // ====================

    // Search starts one past the last winner, so a busy port cannot starve the other
    always_comb
    begin
        int idx;
        grant_any = 1'b0;
        grant_idx = last_q;
        for (int k = 1; k <= local_mem_pkg::NUM_PORTS; k++)
        begin
            idx = (int'(last_q) + k) % local_mem_pkg::NUM_PORTS;
            if (!grant_any && dn_cnt_q != '0 && cnt_q[idx] != '0)
            begin
                grant_any = 1'b1;
                grant_idx = idx[local_mem_pkg::PORT_W-1:0];
            end
        end
    end

    assign down_valid = grant_any;

    // The winner's head goes out with its port tag overwritten
    always_comb
    begin
        down_req      = head[grant_idx];
        down_req.port = grant_idx;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            dn_cnt_q <= local_mem_pkg::map_cnt_t'(local_mem_pkg::MAP_IN_DEPTH);
            last_q   <= '0;
        end
        else
        begin
            case ({down_credit, grant_any})
                2'b10:   dn_cnt_q <= dn_cnt_q + 1'b1;
                2'b01:   dn_cnt_q <= dn_cnt_q - 1'b1;
                default: dn_cnt_q <= dn_cnt_q;
            endcase
            if (grant_any)
            begin
                last_q <= grant_idx;
            end
        end
    end

    // ====================
    // Per-port buffers
    // ====================

    for (genvar i = 0; i < local_mem_pkg::NUM_PORTS; i++)
    begin : g_port
        logic pop;

        assign pop           = grant_any && (grant_idx == local_mem_pkg::port_t'(i));
        assign head[i]       = fifo_q[i][rd_ptr_q[i]];
        // Each pop hands one credit back to the port in the grant cycle
        assign req_credit[i] = pop;

        // The port only sends while holding a credit, so there is always room
        always_ff @(posedge clk)
        begin
            if (req_valid[i])
            begin
                fifo_q[i][wr_ptr_q[i]] <= req[i];
            end
        end

        always_ff @(posedge clk or negedge rst_n)
        begin
            if (!rst_n)
            begin
                wr_ptr_q[i] <= '0;
                rd_ptr_q[i] <= '0;
                cnt_q[i]    <= '0;
            end
            else
            begin
                if (req_valid[i])
                begin
                    wr_ptr_q[i] <= wr_ptr_q[i] + 1'b1;
                end
                if (pop)
                begin
                    rd_ptr_q[i] <= rd_ptr_q[i] + 1'b1;
                end
                case ({req_valid[i], pop})
                    2'b10:   cnt_q[i] <= cnt_q[i] + 1'b1;
                    2'b01:   cnt_q[i] <= cnt_q[i] - 1'b1;
                    default: cnt_q[i] <= cnt_q[i];
                endcase
            end
        end

        // Read beats are steered by the tag the memory copied from the request
        assign rsp_valid[i] = mem_rsp_valid && (mem_rsp.port == local_mem_pkg::port_t'(i));
        assign rsp[i]       = mem_rsp;
    end

endmodule

//--- hw/local_mem_model.sv
// ====================
// On-chip memory model
// Queues requests, performs single-beat writes and streams read
// bursts one beat per cycle from consecutive words
// ====================

module local_mem_model
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req_valid,
    input  local_mem_pkg::mem_req_t req,
    output logic                    req_credit,
    output logic                    rsp_valid,
    output local_mem_pkg::mem_rsp_t rsp
);

    local_mem_pkg::mem_req_t  q_q [local_mem_pkg::MEM_REQ_CREDITS];
    local_mem_pkg::mem_ptr_t  wr_ptr_q;
    local_mem_pkg::mem_ptr_t  rd_ptr_q;
    local_mem_pkg::mem_cnt_t  cnt_q;
    local_mem_pkg::burst_t    beat_q;
    logic [local_mem_pkg::DATA_W-1:0] mem_q [2**local_mem_pkg::ADDR_W];

    local_mem_pkg::mem_req_t  head;
    local_mem_pkg::addr_t     beat_addr;
    logic                     busy;
    logic                     is_read;
    logic                     last_beat;
    logic                     retire;

    assign head      = q_q[rd_ptr_q];
    assign busy      = (cnt_q != '0);
    assign is_read   = busy && (head.cmd == local_mem_pkg::CMD_READ);
    assign beat_addr = head.addr + local_mem_pkg::addr_t'(beat_q);
    assign last_beat = ((beat_q + 1'b1) == head.burst);

    // A write retires the cycle it reaches the head, a read on its last beat
    assign retire     = busy && (!is_read || last_beat);
    assign req_credit = retire;

    // Upstream credits guarantee a free slot for every incoming request
    always_ff @(posedge clk)
    begin
        if (req_valid)
        begin
            q_q[wr_ptr_q] <= req;
        end
        if (busy && !is_read)
        begin
            mem_q[head.addr] <= head.wdata;
        end
        // Beat data lands one cycle after its slot at the head
        rsp.rdata <= mem_q[beat_addr];
        rsp.port  <= head.port;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr_q  <= '0;
            rd_ptr_q  <= '0;
            cnt_q     <= '0;
            beat_q    <= '0;
            rsp_valid <= 1'b0;
        end
        else
        begin
            rsp_valid <= is_read;
            if (req_valid)
            begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (retire)
            begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
                beat_q   <= '0;
            end
            else if (is_read)
            begin
                beat_q <= beat_q + 1'b1;
            end
            case ({req_valid, retire})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;
            endcase
        end
    end

endmodule

//--- hw/local_mem_subsystem.sv
// ====================
// Local memory subsystem top
// Two ports share one memory through arbiter, burst mapper and
// timing pipes
// ====================

module local_mem_subsystem
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req_valid  [local_mem_pkg::NUM_PORTS],
    input  local_mem_pkg::mem_req_t req        [local_mem_pkg::NUM_PORTS],
    output logic                    req_credit [local_mem_pkg::NUM_PORTS],
    output logic                    rsp_valid  [local_mem_pkg::NUM_PORTS],
    output local_mem_pkg::mem_rsp_t rsp        [local_mem_pkg::NUM_PORTS]
);

    // Arbiter to mapper
    logic                    arb_valid;
    local_mem_pkg::mem_req_t arb_req;
    logic                    map_credit;
    // Mapper to request pipe
    logic                    chunk_valid;
    local_mem_pkg::mem_req_t chunk_req;
    logic                    chunk_credit;
    // Request pipe to memory
    logic                    mem_req_valid;
    local_mem_pkg::mem_req_t mem_req;
    logic                    mem_credit;
    // Memory to response pipe, then to the arbiter
    logic                    mem_rsp_valid;
    local_mem_pkg::mem_rsp_t mem_rsp;
    logic                    pipe_rsp_valid;
    local_mem_pkg::mem_rsp_t pipe_rsp;

    mem_port_arbiter arb_i
    (
        .clk, .rst_n, .req_valid, .req, .req_credit,
        .down_valid(arb_valid), .down_req(arb_req), .down_credit(map_credit),
        .mem_rsp_valid(pipe_rsp_valid), .mem_rsp(pipe_rsp), .rsp_valid, .rsp
    );

    burst_mapper mapper_i
    (
        .clk, .rst_n,
        .in_valid(arb_valid), .in_req(arb_req), .in_credit(map_credit),
        .out_valid(chunk_valid), .out_req(chunk_req), .out_credit(chunk_credit)
    );

    // Memory credits return through the same stages as the requests
    credit_reg_pipe
    #(
        .payload_t(local_mem_pkg::mem_req_t),
        .N_REG_STAGES(local_mem_pkg::NUM_TIMING_REG_STAGES)
    )
    req_pipe_i
    (
        .clk, .rst_n,
        .in_valid(chunk_valid), .in_data(chunk_req), .in_credit(chunk_credit),
        .out_valid(mem_req_valid), .out_data(mem_req), .out_credit(mem_credit)
    );

    local_mem_model mem_i
    (
        .clk, .rst_n,
        .req_valid(mem_req_valid), .req(mem_req), .req_credit(mem_credit),
        .rsp_valid(mem_rsp_valid), .rsp(mem_rsp)
    );

    // Ports always sink beats, so the response path carries no credits
    credit_reg_pipe
    #(
        .payload_t(local_mem_pkg::mem_rsp_t),
        .N_REG_STAGES(local_mem_pkg::NUM_TIMING_REG_STAGES)
    )
    rsp_pipe_i
    (
        .clk, .rst_n,
        .in_valid(mem_rsp_valid), .in_data(mem_rsp), .in_credit(),
        .out_valid(pipe_rsp_valid), .out_data(pipe_rsp), .out_credit(1'b0)
    );

endmodule

//--- test/local_mem_tb_ref.svh
// ====================
// Testbench reference model
// Shadow memory, per-port expected read beats and typed compare tasks
// ====================

`ifndef LOCAL_MEM_TB_REF_SVH
`define LOCAL_MEM_TB_REF_SVH

// Shadow copy of the memory, updated in each port's issue order
logic [local_mem_pkg::DATA_W-1:0] shadow [2**local_mem_pkg::ADDR_W];
// Beats each port still has to receive, oldest first
local_mem_pkg::mem_rsp_t exp_q [local_mem_pkg::NUM_PORTS][$];
int data_errors     = 0;
int credit_errors   = 0;
int protocol_errors = 0;

// A write updates the shadow memory, a read queues one beat per word of its burst
function automatic void expected_beats(input local_mem_pkg::port_t p,
                                       input local_mem_pkg::mem_req_t r);
    local_mem_pkg::mem_rsp_t e;
    if (r.cmd == local_mem_pkg::CMD_WRITE)
    begin
        shadow[r.addr] = r.wdata;
    end
    else
    begin
        for (int k = 0; k < int'(r.burst); k++)
        begin
            e.rdata = shadow[r.addr + local_mem_pkg::addr_t'(k)];
            e.port  = p;
            exp_q[p].push_back(e);
        end
    end
endfunction

task automatic check_rsp(input int p, input local_mem_pkg::mem_rsp_t got,
                         input local_mem_pkg::mem_rsp_t want);
    if (got.rdata !== want.rdata)
    begin
        $display("MISMATCH rsp[%0d].rdata got 0x%08h expected 0x%08h", p, got.rdata, want.rdata);
        data_errors++;
    end
    if (got.port !== want.port)
    begin
        $display("MISMATCH rsp[%0d].port got 0x%0h expected 0x%0h", p, got.port, want.port);
        data_errors++;
    end
endtask

// A port never holds more than the credits it owns after reset
task automatic check_credit(input int p, input int count);
    if (count > local_mem_pkg::PORT_REQ_CREDITS)
    begin
        $display("Port %0d holds %0d credits, more than the %0d it owns",
                 p, count, local_mem_pkg::PORT_REQ_CREDITS);
        credit_errors++;
    end
endtask

`endif

//--- test/local_mem_tb.sv
// ====================
// Local memory subsystem testbench
// Two ports issue writes and bursts of reads under credits, every read
// beat is compared with a shadow memory
// ====================

module local_mem_tb;

    // Each port owns a private window so cross-port ordering never matters
    localparam int REGION     = 64;
    localparam int PORT_SPAN  = 512;
    localparam int RAND_REQS  = 300;
    localparam int TOTAL_REQS = local_mem_pkg::NUM_PORTS * (2 + REGION + 1 + RAND_REQS);
    localparam int TIMEOUT_CYCLES = 200 * TOTAL_REQS + 1000;

    logic                    clk = 1'b0;
    logic                    rst_n = 1'b0;
    logic                    req_valid  [local_mem_pkg::NUM_PORTS];
    local_mem_pkg::mem_req_t req        [local_mem_pkg::NUM_PORTS];
    logic                    req_credit [local_mem_pkg::NUM_PORTS];
    logic                    rsp_valid  [local_mem_pkg::NUM_PORTS];
    local_mem_pkg::mem_rsp_t rsp        [local_mem_pkg::NUM_PORTS];

    // Requests waiting for a credit, and per-port credit bookkeeping
    local_mem_pkg::mem_req_t pend_q [local_mem_pkg::NUM_PORTS][$];
    int credits  [local_mem_pkg::NUM_PORTS];
    int beats = 0;

    `include "local_mem_tb_ref.svh"

    local_mem_subsystem dut_i
    (
        .clk, .rst_n, .req_valid, .req, .req_credit, .rsp_valid, .rsp
    );

    always #10 clk = ~clk;

    task automatic queue_request(input int p, input local_mem_pkg::mem_cmd_e cmd,
                                 input int addr, input int burst,
                                 input logic [local_mem_pkg::DATA_W-1:0] wdata);
        local_mem_pkg::mem_req_t r;
        r.cmd   = cmd;
        r.addr  = local_mem_pkg::addr_t'(p * PORT_SPAN + addr);
        r.burst = local_mem_pkg::burst_t'(burst);
        r.wdata = wdata;
        r.port  = '0;
        pend_q[p].push_back(r);
    endtask

    // Reads stay inside the port's window, which is fully written beforehand
    task automatic queue_random(input int p);
        int burst;
        if ($urandom_range(0, 1) == 0)
        begin
            queue_request(p, local_mem_pkg::CMD_WRITE, int'($urandom_range(0, REGION - 1)),
                          1, $urandom());
        end
        else
        begin
            burst = int'($urandom_range(1, 16));
            queue_request(p, local_mem_pkg::CMD_READ,
                          int'($urandom_range(0, REGION - burst)), burst, '0);
        end
    endtask

    // Idle means nothing pending, no beat outstanding and every credit home
    task automatic wait_until_idle();
        logic idle;
        idle = 1'b0;
        while (!idle)
        begin
            @(posedge clk);
            idle = 1'b1;
            for (int p = 0; p < local_mem_pkg::NUM_PORTS; p++)
            begin
                if (pend_q[p].size() != 0 || exp_q[p].size() != 0 ||
                    credits[p] != local_mem_pkg::PORT_REQ_CREDITS)
                begin
                    idle = 1'b0;
                end
            end
        end
    endtask

    // ====================
    // Port drivers
    // ====================

    // Credits are collected and spent on the falling edge, mid-cycle
    initial
    begin : drive_ports
        local_mem_pkg::mem_req_t r;
        for (int p = 0; p < local_mem_pkg::NUM_PORTS; p++)
        begin
            req_valid[p] = 1'b0;
            req[p]       = '0;
            credits[p]   = local_mem_pkg::PORT_REQ_CREDITS;
        end
        forever
        begin
            @(negedge clk);
            for (int p = 0; p < local_mem_pkg::NUM_PORTS; p++)
            begin
                if (req_credit[p] === 1'b1)
                begin
                    credits[p]++;
                    check_credit(p, credits[p]);
                end
                if (rst_n && pend_q[p].size() != 0 && credits[p] > 0)
                begin
                    r = pend_q[p].pop_front();
                    req_valid[p] = 1'b1;
                    req[p]       = r;
                    credits[p]--;
                    expected_beats(local_mem_pkg::port_t'(p), r);
                end
                else
                begin
                    req_valid[p] = 1'b0;
                end
            end
        end
    end

    // Every beat must belong to an outstanding read of the same port
    initial
    begin : compare_rsp
        local_mem_pkg::mem_rsp_t want;
        forever
        begin
            @(negedge clk);
            for (int p = 0; p < local_mem_pkg::NUM_PORTS; p++)
            begin
                if (rst_n && rsp_valid[p] === 1'b1)
                begin
                    beats++;
                    if (exp_q[p].size() == 0)
                    begin
                        $display("Port %0d received a read beat with no read outstanding", p);
                        protocol_errors++;
                    end
                    else
                    begin
                        want = exp_q[p].pop_front();
                        check_rsp(p, rsp[p], want);
                    end
                end
            end
        end
    end

    initial
    begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles with requests, read beats or credits outstanding",
                 TIMEOUT_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // ====================
    // Test sequence
    // ====================

    initial
    begin : run_tests
        int total_errors;
        void'($urandom(32'h8b530b76));
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Single write then single-beat read on both ports at once
        for (int p = 0; p < local_mem_pkg::NUM_PORTS; p++)
        begin
            queue_request(p, local_mem_pkg::CMD_WRITE, 0, 1, $urandom());
            queue_request(p, local_mem_pkg::CMD_READ, 0, 1, '0);
        end
        wait_until_idle();

        // Fill both windows with interleaved writes from the two ports
        for (int i = 0; i < REGION; i++)
        begin
            for (int p = 0; p < local_mem_pkg::NUM_PORTS; p++)
            begin
                queue_request(p, local_mem_pkg::CMD_WRITE, i, 1, $urandom());
            end
        end
        wait_until_idle();

        // Sixteen beats per port, cut into four memory bursts inside
        for (int p = 0; p < local_mem_pkg::NUM_PORTS; p++)
        begin
            queue_request(p, local_mem_pkg::CMD_READ, 8, 16, '0);
        end
        wait_until_idle();

        // Random mix of writes and reads on both ports together
        for (int i = 0; i < RAND_REQS; i++)
        begin
            for (int p = 0; p < local_mem_pkg::NUM_PORTS; p++)
            begin
                queue_random(p);
            end
        end
        wait_until_idle();
        // Stray beats or credit pulses after idle are caught by the two processes above
        repeat (10) @(posedge clk);

        total_errors = data_errors + credit_errors + protocol_errors;
        $display("Errors: data %0d, credit %0d, protocol %0d (%0d beats checked)",
                 data_errors, credit_errors, protocol_errors, beats);
        if (total_errors == 0)
        begin
            $display("*** TEST PASSED ***");
        end
        else
        begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+test
hw/local_mem_pkg.sv
hw/credit_reg_pipe.sv
hw/burst_mapper.sv
hw/mem_port_arbiter.sv
hw/local_mem_model.sv
hw/local_mem_subsystem.sv
test/local_mem_tb.sv

//--- run.sh
#!/bin/sh
# Builds the local memory subsystem testbench with Verilator and runs it.
# The exit status is 0 only when the run prints the pass message.
verilator --binary --timing -f build.f --top-module local_mem_tb -o local_mem_tb_sim \
    && ./obj_dir/local_mem_tb_sim | tee /dev/stderr | grep -qF '*** TEST PASSED ***' \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
